//--- Bender.yml
package:
  name: ctrl_unit

sources:
  - design/ctrlPkg.sv
  - design/decodeIf.sv
  - design/instrDecoder.sv
  - design/phaseSequencer.sv
  - design/ctrlWordGen.sv
  - design/ctrlUnit.sv
  - target: simulation
    files:
      - dv/ctrlUnit_props.sv
      - dv/ctrlUnitTb.sv

//--- design/ctrlPkg.sv
package ctrlPkg;

    localparam int OpcodeWidth = 6;
    localparam int FunctWidth  = 6;

    typedef enum logic [OpcodeWidth-1:0] {
        opRType = 6'b000000,
        opAddi  = 6'b001000,
        opAddiu = 6'b001001,
        opBeq   = 6'b000100,
        opBne   = 6'b000101,
        opBle   = 6'b000110,
        opBgt   = 6'b000111
    } opcode_t;

    typedef enum logic [FunctWidth-1:0] {
        fnAdd  = 6'b100000,
        fnAnd  = 6'b100100,
        fnSub  = 6'b100010,
        fnMult = 6'b011000,
        fnDiv  = 6'b011010,
        fnMfhi = 6'b010000,
        fnMflo = 6'b010010
    } funct_t;

    typedef enum logic [3:0] {
        clsAluReg,
        clsAluImm,
        clsAluImmU,
        clsMult,
        clsDiv,
        clsMoveHi,
        clsMoveLo,
        clsBranch,
        clsIllegal
    } opClass_t;

    typedef enum logic [2:0] {
        aluPass    = 3'b000,
        aluAdd     = 3'b001,
        aluSub     = 3'b010,
        aluAnd     = 3'b011,
        aluCompare = 3'b111   // Drives the eq/gt/lt flags
    } aluOp_t;

    typedef enum logic [1:0] {
        brEqual,
        brNotEqual,
        brLessOrEqual,
        brGreater
    } branchCond_t;

    typedef enum logic [4:0] {
        phFetch,
        phPcUpdate,
        phPrecalc,     // Branch target into ALUOut
        phDecode,      // Operands into A and B
        phExec,
        phSaveResult,
        phMultStart,
        phMultWait,
        phMultResult,
        phDivStart,
        phDivWait,
        phDivResult,
        phMoveHi,
        phMoveLo,
        phBranchCmp,
        phBranchTake,
        phTrap
    } phase_t;

    typedef enum logic [1:0] {
        trapNone,
        trapIllegal,
        trapOverflow
    } trapCause_t;

    typedef enum logic [1:0] {srcAPc = 2'b00, srcARegA = 2'b01} aluSrcA_t;

    typedef enum logic [2:0] {
        srcBRegB         = 3'b000,
        srcBFour         = 3'b001,
        srcBBranchOffset = 3'b010,   // Sign-extended offset shifted by 2
        srcBImm          = 3'b011
    } aluSrcB_t;

    typedef enum logic [1:0] {pcAluResult = 2'b00, pcAluOut = 2'b10} pcSrc_t;

    typedef enum logic [1:0] {regDstRd = 2'b00, regDstRt = 2'b11} regDst_t;

    typedef enum logic [2:0] {wbAluOut = 3'b000, wbLo = 3'b001, wbHi = 3'b010} wbSrc_t;

endpackage

//--- design/ctrlUnit.sv
`timescale 1ns/1ps

module ctrlUnit #(
    parameter int MemWaitCycles = 3
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [ctrlPkg::OpcodeWidth-1:0]  opcode,
    input  logic [ctrlPkg::FunctWidth-1:0]   funct,
    input  logic                             overflow,
    input  logic                             equal,
    input  logic                             greater,
    input  logic                             less,
    input  logic                             multEnd,
    input  logic                             divEnd,
    output logic                             writePc,
    output logic                             writeA,
    output logic                             writeB,
    output logic                             writeAluOut,
    output logic                             writeInstruction,
    output logic                             writeReg,
    output logic                             writeHiLo,
    output logic                             multCtrl,
    output logic                             divCtrl,
    output logic                             hiLoCtrl,
    output logic [1:0]                       aluSrcACtrl,
    output logic [2:0]                       aluSrcBCtrl,
    output logic [1:0]                       pcSrcCtrl,
    output logic [1:0]                       writeRegCtrl,
    output logic [2:0]                       writeDataCtrl,
    output logic [2:0]                       aluCtrl,
    output logic [1:0]                       trapCause
);
    import ctrlPkg::*;

    phase_t phase;

    decodeIf dec ();

    instrDecoder uDecoder (
        .opcode (opcode_t'(opcode)),
        .funct  (funct_t'(funct)),
        .dec    (dec.producer)
    );

    phaseSequencer #(
        .MemWaitCycles (MemWaitCycles)
    ) uSequencer (
        .clk       (clk),
        .reset     (reset),
        .dec       (dec.sequencer),
        .overflow  (overflow),
        .equal     (equal),
        .greater   (greater),
        .less      (less),
        .multEnd   (multEnd),
        .divEnd    (divEnd),
        .phase     (phase),
        .trapCause (trapCause)
    );

    ctrlWordGen uWordGen (
        .phase            (phase),
        .dec              (dec.consumer),
        .writePc          (writePc),
        .writeA           (writeA),
        .writeB           (writeB),
        .writeAluOut      (writeAluOut),
        .writeInstruction (writeInstruction),
        .writeReg         (writeReg),
        .writeHiLo        (writeHiLo),
        .multCtrl         (multCtrl),
        .divCtrl          (divCtrl),
        .hiLoCtrl         (hiLoCtrl),
        .aluSrcACtrl      (aluSrcACtrl),
        .aluSrcBCtrl      (aluSrcBCtrl),
        .pcSrcCtrl        (pcSrcCtrl),
        .writeRegCtrl     (writeRegCtrl),
        .writeDataCtrl    (writeDataCtrl),
        .aluCtrl          (aluCtrl)
    );

endmodule

//--- design/ctrlWordGen.sv
`timescale 1ns/1ps

module ctrlWordGen (
    input  ctrlPkg::phase_t     phase,
    decodeIf.consumer           dec,
    output logic                writePc,
    output logic                writeA,
    output logic                writeB,
    output logic                writeAluOut,
    output logic                writeInstruction,
    output logic                writeReg,
    output logic                writeHiLo,
    output logic                multCtrl,
    output logic                divCtrl,
    output logic                hiLoCtrl,
    output ctrlPkg::aluSrcA_t   aluSrcACtrl,
    output ctrlPkg::aluSrcB_t   aluSrcBCtrl,
    output ctrlPkg::pcSrc_t     pcSrcCtrl,
    output ctrlPkg::regDst_t    writeRegCtrl,
    output ctrlPkg::wbSrc_t     writeDataCtrl,
    output ctrlPkg::aluOp_t     aluCtrl
);
    import ctrlPkg::*;

    always_comb begin
        writePc          = 1'b0;
        writeA           = 1'b0;
        writeB           = 1'b0;
        writeAluOut      = 1'b0;
        writeInstruction = 1'b0;
        writeReg         = 1'b0;
        writeHiLo        = 1'b0;
        multCtrl         = 1'b0;
        divCtrl          = 1'b0;
        hiLoCtrl         = 1'b0;
        aluSrcACtrl      = srcAPc;
        aluSrcBCtrl      = srcBRegB;
        pcSrcCtrl        = pcAluResult;
        writeRegCtrl     = regDstRd;
        writeDataCtrl    = wbAluOut;
        aluCtrl          = aluPass;
        case (phase)
            phFetch: begin
                writeInstruction = 1'b1;
                writeAluOut      = 1'b1;   // PC + 4
                aluSrcBCtrl      = srcBFour;
                aluCtrl          = aluAdd;
            end
            phPcUpdate: begin
                writePc   = 1'b1;
                pcSrcCtrl = pcAluOut;
            end
            phPrecalc: begin
                writeAluOut = 1'b1;
                aluSrcBCtrl = srcBBranchOffset;
                aluCtrl     = aluAdd;
            end
            phDecode: begin
                writeA = 1'b1;
                writeB = 1'b1;
            end
            phExec: begin
                writeAluOut = 1'b1;
                aluSrcACtrl = srcARegA;
                aluSrcBCtrl = dec.immOperand ? srcBImm : srcBRegB;
                aluCtrl     = dec.aluOp;
            end
            phSaveResult: begin
                writeReg     = 1'b1;
                writeRegCtrl = dec.immOperand ? regDstRt : regDstRd;
            end
            phMultStart: multCtrl = 1'b1;
            phDivStart:  divCtrl  = 1'b1;
            phMultResult: writeHiLo = 1'b1;
            phDivResult: begin
                writeHiLo = 1'b1;
                hiLoCtrl  = 1'b1;   // Take results from the divider
            end
            phMoveHi: begin
                writeReg      = 1'b1;
                writeDataCtrl = wbHi;
            end
            phMoveLo: begin
                writeReg      = 1'b1;
                writeDataCtrl = wbLo;
            end
            phBranchCmp: begin
                aluSrcACtrl = srcARegA;
                aluCtrl     = aluCompare;   // ALUOut keeps the target
            end
            phBranchTake: begin
                writePc   = 1'b1;
                pcSrcCtrl = pcAluOut;
            end
            default: ;
        endcase
    end

endmodule

//--- design/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;
    import ctrlPkg::*;

    opClass_t    opClass;
    aluOp_t      aluOp;
    logic        immOperand;     // B operand is the immediate
    logic        checkOverflow;
    branchCond_t branchCond;

    modport producer (
        output opClass, aluOp, immOperand, checkOverflow, branchCond
    );

    modport sequencer (
        input opClass, checkOverflow, branchCond
    );

    modport consumer (
        input aluOp, immOperand
    );

endinterface

//--- design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  ctrlPkg::opcode_t opcode,
    input  ctrlPkg::funct_t  funct,
    decodeIf.producer        dec
);
    import ctrlPkg::*;

    always_comb begin
        dec.opClass       = clsIllegal;   // Anything unlisted traps
        dec.aluOp         = aluPass;
        dec.immOperand    = 1'b0;
        dec.checkOverflow = 1'b0;
        dec.branchCond    = brEqual;
        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd: begin
                        dec.opClass       = clsAluReg;
                        dec.aluOp         = aluAdd;
                        dec.checkOverflow = 1'b1;
                    end
                    fnSub: begin
                        dec.opClass       = clsAluReg;
                        dec.aluOp         = aluSub;
                        dec.checkOverflow = 1'b1;
                    end
                    fnAnd: begin
                        dec.opClass = clsAluReg;
                        dec.aluOp   = aluAnd;
                    end
                    fnMult: dec.opClass = clsMult;
                    fnDiv:  dec.opClass = clsDiv;
                    fnMfhi: dec.opClass = clsMoveHi;
                    fnMflo: dec.opClass = clsMoveLo;
                    default: dec.opClass = clsIllegal;
                endcase
            end
            opAddi: begin
                dec.opClass       = clsAluImm;
                dec.aluOp         = aluAdd;
                dec.immOperand    = 1'b1;
                dec.checkOverflow = 1'b1;
            end
            opAddiu: begin
                dec.opClass    = clsAluImmU;    // Same add, overflow ignored
                dec.aluOp      = aluAdd;
                dec.immOperand = 1'b1;
            end
            opBeq, opBne, opBle, opBgt: begin
                dec.opClass = clsBranch;
                dec.aluOp   = aluCompare;
                case (opcode)
                    opBne:   dec.branchCond = brNotEqual;
                    opBle:   dec.branchCond = brLessOrEqual;
                    opBgt:   dec.branchCond = brGreater;
                    default: dec.branchCond = brEqual;
                endcase
            end
            default: dec.opClass = clsIllegal;
        endcase
    end

endmodule

//--- design/phaseSequencer.sv
`timescale 1ns/1ps

module phaseSequencer #(
    parameter int MemWaitCycles = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    decodeIf.sequencer           dec,
    input  logic                 overflow,
    input  logic                 equal,
    input  logic                 greater,
    input  logic                 less,
    input  logic                 multEnd,
    input  logic                 divEnd,
    output ctrlPkg::phase_t      phase,
    output ctrlPkg::trapCause_t  trapCause
);
    import ctrlPkg::*;

    localparam int WaitWidth = (MemWaitCycles > 1) ? $clog2(MemWaitCycles) : 1;
    localparam logic [WaitWidth-1:0] LastWait = WaitWidth'(MemWaitCycles - 1);

    logic [WaitWidth-1:0] waitCnt;
    phase_t               nextPhase;
    trapCause_t           nextCause;
    logic                 branchTaken;

    always_comb begin
        case (dec.branchCond)
            brEqual:       branchTaken = equal;
            brNotEqual:    branchTaken = !equal;
            brLessOrEqual: branchTaken = equal || less;
            default:       branchTaken = greater;
        endcase
    end

    always_comb begin
        nextPhase = phase;
        nextCause = trapCause;   // Cause only changes on trap entry
        case (phase)
            phFetch: begin
                if (waitCnt == LastWait) begin
                    nextPhase = phPcUpdate;
                end
            end
            phPcUpdate: nextPhase = phPrecalc;
            phPrecalc:  nextPhase = phDecode;
            phDecode: begin
                case (dec.opClass)
                    clsAluReg, clsAluImm, clsAluImmU: nextPhase = phExec;
                    clsMult:   nextPhase = phMultStart;
                    clsDiv:    nextPhase = phDivStart;
                    clsMoveHi: nextPhase = phMoveHi;
                    clsMoveLo: nextPhase = phMoveLo;
                    clsBranch: nextPhase = phBranchCmp;
                    default: begin
                        nextPhase = phTrap;
                        nextCause = trapIllegal;
                    end
                endcase
            end
            phExec: begin
                if (dec.checkOverflow && overflow) begin
                    nextPhase = phTrap;
                    nextCause = trapOverflow;
                end else begin
                    nextPhase = phSaveResult;
                end
            end
            phMultStart: nextPhase = phMultWait;
            phMultWait: begin
                if (multEnd) begin
                    nextPhase = phMultResult;
                end
            end
            phDivStart: nextPhase = phDivWait;
            phDivWait: begin
                if (divEnd) begin
                    nextPhase = phDivResult;
                end
            end
            phBranchCmp: nextPhase = branchTaken ? phBranchTake : phFetch;
            phTrap:      nextPhase = phTrap;   // Parked until reset
            default:     nextPhase = phFetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= phFetch;
            waitCnt   <= '0;
            trapCause <= trapNone;
        end else begin
            phase     <= nextPhase;
            trapCause <= nextCause;
            if (phase == phFetch && waitCnt != LastWait) begin
                waitCnt <= waitCnt + 1'b1;
            end else begin
                waitCnt <= '0;
            end
        end
    end

endmodule

//--- dv/ctrlUnitTb.sv
`timescale 1ns/1ps

module ctrlUnitTb;
    import ctrlPkg::*;

    localparam int MemWait   = 3;
    localparam int NumInstr  = 300;
    localparam int NumKinds  = 15;
    localparam int ClkPeriod = 8;
    localparam int Timeout   = (40 * NumInstr + 200) * ClkPeriod;

    typedef enum int {
        kAdd, kAnd, kSub, kAddi, kAddiu, kMult, kDiv, kMfhi, kMflo,
        kBeq, kBne, kBle, kBgt, kBadOp, kBadFunct
    } kind_t;

    typedef enum int {
        mFetch, mPcUpdate, mPrecalc, mDecode, mExec, mSave, mMultStart, mMultWait,
        mMultResult, mDivStart, mDivWait, mDivResult, mMoveHi, mMoveLo,
        mBranchCmp, mBranchTake, mTrap
    } modelPhase_t;

    logic clk, reset, overflow, equal, greater, less, multEnd, divEnd;
    logic [5:0] opcode, funct;
    logic writePc, writeA, writeB, writeAluOut, writeInstruction;
    logic writeReg, writeHiLo, multCtrl, divCtrl, hiLoCtrl;
    logic [1:0] aluSrcACtrl, pcSrcCtrl, writeRegCtrl, trapCause;
    logic [2:0] aluSrcBCtrl, writeDataCtrl, aluCtrl;

    modelPhase_t mPhase;
    kind_t       kind;
    logic [1:0]  mCause;
    string       testName;
    int mWait, endWait, resetLeft, trapCycles, instrCount;
    int takenCnt, notTakenCnt, ovTrapCnt, missing;
    int seen [NumKinds];

    ctrlUnit #(.MemWaitCycles(MemWait)) dut (
        .clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
        .overflow(overflow), .equal(equal), .greater(greater), .less(less),
        .multEnd(multEnd), .divEnd(divEnd),
        .writePc(writePc), .writeA(writeA), .writeB(writeB),
        .writeAluOut(writeAluOut), .writeInstruction(writeInstruction),
        .writeReg(writeReg), .writeHiLo(writeHiLo), .multCtrl(multCtrl),
        .divCtrl(divCtrl), .hiLoCtrl(hiLoCtrl), .aluSrcACtrl(aluSrcACtrl),
        .aluSrcBCtrl(aluSrcBCtrl), .pcSrcCtrl(pcSrcCtrl), .writeRegCtrl(writeRegCtrl),
        .writeDataCtrl(writeDataCtrl), .aluCtrl(aluCtrl), .trapCause(trapCause)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic checkValue(input string what, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s, %s: expected %0h, actual %0h",
                     testName, what, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    function automatic logic isKeptOpcode(input logic [5:0] code);
        return code == 6'b000000 || code == 6'b001000 || code == 6'b001001 ||
               (code >= 6'b000100 && code <= 6'b000111);
    endfunction

    function automatic logic isKeptFunct(input logic [5:0] code);
        return code == 6'b100000 || code == 6'b100100 || code == 6'b100010 ||
               code == 6'b011000 || code == 6'b011010 || code == 6'b010000 ||
               code == 6'b010010;
    endfunction

    task automatic pickInstruction();
        logic [5:0] code;
        kind = kind_t'($urandom % NumKinds);
        code = 6'($urandom);
        opcode = 6'b000000;
        funct = 6'($urandom);   // Don't care outside R-type
        case (kind)
            kAdd:      funct = 6'b100000;
            kAnd:      funct = 6'b100100;
            kSub:      funct = 6'b100010;
            kMult:     funct = 6'b011000;
            kDiv:      funct = 6'b011010;
            kMfhi:     funct = 6'b010000;
            kMflo:     funct = 6'b010010;
            kAddi:     opcode = 6'b001000;
            kAddiu:    opcode = 6'b001001;
            kBeq:      opcode = 6'b000100;
            kBne:      opcode = 6'b000101;
            kBle:      opcode = 6'b000110;
            kBgt:      opcode = 6'b000111;
            kBadOp:    opcode = isKeptOpcode(code) ? 6'b100011 : code;
            default:   funct = isKeptFunct(code) ? 6'b001000 : code;
        endcase
        seen[kind]++;
        instrCount++;
        testName = kind.name();
    endtask

    function automatic logic branchTaken();
        case (kind)
            kBeq:    return equal;
            kBne:    return !equal;
            kBle:    return equal || less;
            default: return greater;
        endcase
    endfunction

    // Next phase from the inputs seen at the last edge
    task automatic modelStep();
        if (reset) begin
            mPhase = mFetch;
            mWait = 0;
            mCause = trapNone;
        end else begin
            case (mPhase)
                mFetch: begin
                    if (mWait == MemWait - 1) begin
                        mPhase = mPcUpdate;
                        mWait = 0;
                    end else begin
                        mWait++;
                    end
                end
                mPcUpdate: mPhase = mPrecalc;
                mPrecalc:  mPhase = mDecode;
                mDecode: begin
                    case (kind)
                        kAdd, kAnd, kSub, kAddi, kAddiu: mPhase = mExec;
                        kMult: mPhase = mMultStart;
                        kDiv:  mPhase = mDivStart;
                        kMfhi: mPhase = mMoveHi;
                        kMflo: mPhase = mMoveLo;
                        kBadOp, kBadFunct: begin
                            mPhase = mTrap;
                            mCause = trapIllegal;
                        end
                        default: mPhase = mBranchCmp;
                    endcase
                end
                mExec: begin
                    if (overflow && (kind == kAdd || kind == kSub || kind == kAddi)) begin
                        mPhase = mTrap;
                        mCause = trapOverflow;
                        ovTrapCnt++;
                    end else begin
                        mPhase = mSave;
                    end
                end
                mMultStart: begin
                    mPhase = mMultWait;
                    endWait = $urandom % 6;
                end
                mDivStart: begin
                    mPhase = mDivWait;
                    endWait = $urandom % 6;
                end
                mMultWait: if (multEnd) mPhase = mMultResult;
                mDivWait:  if (divEnd) mPhase = mDivResult;
                mBranchCmp: begin
                    if (branchTaken()) begin
                        takenCnt++;
                        mPhase = mBranchTake;
                    end else begin
                        notTakenCnt++;
                        mPhase = mFetch;
                    end
                end
                mTrap: mPhase = mTrap;
                default: mPhase = mFetch;
            endcase
        end
    endtask

    task automatic driveInputs();
        int cmp;
        if (resetLeft > 0) resetLeft--;
        if (mPhase == mTrap) begin
            trapCycles++;
            if (trapCycles == 4) begin
                resetLeft = 5;   // Only reset leaves the trap
                trapCycles = 0;
            end
        end
        reset = (resetLeft > 0);
        if (!reset && mPhase == mFetch && mWait == 0) pickInstruction();
        cmp = $urandom % 3;
        equal = (cmp == 0);
        greater = (cmp == 1);
        less = (cmp == 2);
        overflow = ($urandom % 8 == 0);
        multEnd = 1'b0;
        divEnd = 1'b0;
        if (mPhase == mMultWait || mPhase == mDivWait) begin
            if (endWait == 0) begin
                multEnd = (mPhase == mMultWait);
                divEnd = (mPhase == mDivWait);
            end else begin
                endWait--;
            end
        end
    endtask

    task automatic checkOutputs();
        logic [9:0] en;   // writePc A B AluOut Instruction Reg HiLo mult div hiLo
        logic [1:0] srcA, pcSel, regDst;
        logic [2:0] srcB, wbSel, alu;
        logic imm;
        imm = (kind == kAddi || kind == kAddiu);
        en = '0;
        srcA = srcAPc;
        srcB = srcBRegB;
        pcSel = pcAluResult;
        regDst = regDstRd;
        wbSel = wbAluOut;
        alu = aluPass;
        case (mPhase)
            mFetch: begin
                en = 10'b0001100000;
                srcB = srcBFour;
                alu = aluAdd;
            end
            mPcUpdate, mBranchTake: begin
                en = 10'b1000000000;
                pcSel = pcAluOut;
            end
            mPrecalc: begin
                en = 10'b0001000000;
                srcB = srcBBranchOffset;
                alu = aluAdd;
            end
            mDecode: en = 10'b0110000000;
            mExec: begin
                en = 10'b0001000000;
                srcA = srcARegA;
                srcB = imm ? srcBImm : srcBRegB;
                alu = (kind == kSub) ? aluSub : (kind == kAnd) ? aluAnd : aluAdd;
            end
            mSave: begin
                en = 10'b0000010000;
                regDst = imm ? regDstRt : regDstRd;
            end
            mMultStart:  en = 10'b0000000100;
            mDivStart:   en = 10'b0000000010;
            mMultResult: en = 10'b0000001000;
            mDivResult:  en = 10'b0000001001;
            mMoveHi: begin
                en = 10'b0000010000;
                wbSel = wbHi;
            end
            mMoveLo: begin
                en = 10'b0000010000;
                wbSel = wbLo;
            end
            mBranchCmp: begin
                srcA = srcARegA;
                alu = aluCompare;
            end
            default: ;
        endcase
        checkValue("write enables", en, {writePc, writeA, writeB, writeAluOut,
                   writeInstruction, writeReg, writeHiLo, multCtrl, divCtrl, hiLoCtrl});
        checkValue("aluSrcACtrl", srcA, aluSrcACtrl);
        checkValue("aluSrcBCtrl", srcB, aluSrcBCtrl);
        checkValue("pcSrcCtrl", pcSel, pcSrcCtrl);
        checkValue("writeRegCtrl", regDst, writeRegCtrl);
        checkValue("writeDataCtrl", wbSel, writeDataCtrl);
        checkValue("aluCtrl", alu, aluCtrl);
        checkValue("trapCause", mCause, trapCause);
    endtask

    initial begin
        #(Timeout);
        $display("Watchdog expired before %0d instructions were run", NumInstr);
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        void'($urandom(41));
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        {overflow, equal, greater, less, multEnd, divEnd} = '0;
        mPhase = mFetch;
        mCause = trapNone;
        kind = kAdd;
        testName = "reset";
        resetLeft = 5;
        mWait = 0;
        endWait = 0;
        trapCycles = 0;
        instrCount = 0;
        takenCnt = 0;
        notTakenCnt = 0;
        ovTrapCnt = 0;
        while (instrCount < NumInstr) begin
            @(posedge clk);
            #1;
            modelStep();
            driveInputs();
            #3;
            checkOutputs();
        end
        missing = 0;
        for (int i = 0; i < NumKinds; i++) begin
            if (seen[i] == 0) missing++;
        end
        if (missing != 0 || takenCnt == 0 || notTakenCnt == 0 || ovTrapCnt == 0) begin
            $display("Stimulus missed %0d instruction kinds or a branch or overflow path",
                     missing);
            $display("SOME TESTS FAILED");
            $fatal(1, "Coverage hole");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- dv/ctrlUnit_props.sv
`timescale 1ns/1ps

module ctrlUnitProps (
    input logic       clk,
    input logic       reset,
    input logic       writeInstruction,
    input logic       writeReg,
    input logic       writeHiLo,
    input logic       multCtrl,
    input logic       divCtrl,
    input logic [1:0] trapCause
);
    logic startSeen;   // Mult or div started since the last fetch

    always_ff @(posedge clk) begin
        if (reset || writeInstruction) begin
            startSeen <= 1'b0;
        end else if (multCtrl || divCtrl) begin
            startSeen <= 1'b1;
        end
    end

    fetchNotWriteback: assert property (@(posedge clk) disable iff (reset)
        !(writeInstruction && writeReg))
        else $error("writeInstruction and writeReg high in the same cycle");

    hiLoAfterStart: assert property (@(posedge clk) disable iff (reset)
        writeHiLo |-> startSeen)
        else $error("writeHiLo without a mult or div start in this instruction");

    causeHeld: assert property (@(posedge clk) disable iff (reset)
        (trapCause != 2'b00) |=> $stable(trapCause))
        else $error("Trap cause changed after it was set");

endmodule

bind ctrlUnit ctrlUnitProps uProps (
    .clk              (clk),
    .reset            (reset),
    .writeInstruction (writeInstruction),
    .writeReg         (writeReg),
    .writeHiLo        (writeHiLo),
    .multCtrl         (multCtrl),
    .divCtrl          (divCtrl),
    .trapCause        (trapCause)
);

//--- project.f
design/ctrlPkg.sv
design/decodeIf.sv
design/instrDecoder.sv
design/phaseSequencer.sv
design/ctrlWordGen.sv
design/ctrlUnit.sv
dv/ctrlUnit_props.sv
dv/ctrlUnitTb.sv
